// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator.
# Exit status is 0 only when the run prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module tb_ex_stage -f vlog.f -o sim_ex_stage
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_ex_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
    exit 0
else
    echo "Simulation did not report a pass"
    exit 1
fi

// ==== sim/ex_stage_assert.sv ====
/*
  Handshake properties of the execute stage, bound into ex_stage_top.
  Ports connect by name to the top level signals.
*/
`timescale 1ns/1ns

module ex_stage_assert (
    input logic        g_clk,
    input logic        i_rst_n,
    input logic        i_flush,
    input logic        i_busy,
    input logic        o_valid,
    input logic        o_busy,
    input logic [4:0]  o_rd,
    input logic [31:0] o_res_a,
    input logic [31:0] o_res_b,
    input logic [4:0]  o_uop,
    input logic [3:0]  o_fu,
    input logic        o_trap
);

    logic [78:0] payload;  // All registered outputs

    assign payload = {o_rd, o_res_a, o_res_b, o_uop, o_fu, o_trap};

    // ----------------------------------------------------------------------
    // Reset and handshake
    // ----------------------------------------------------------------------
    a_reset_clear: assert property (@(posedge g_clk) !i_rst_n |=> !o_valid)
        else $error("o_valid high after reset");

    a_busy_rule: assert property (@(posedge g_clk) disable iff (!i_rst_n)
        o_busy == (o_valid && i_busy))
        else $error("o_busy differs from o_valid and i_busy");

    // Held item stays put under back-pressure
    a_hold: assert property (@(posedge g_clk) disable iff (!i_rst_n)
        (o_valid && i_busy && !i_flush) |=> (o_valid && $stable(payload)))
        else $error("Outputs changed while stalled");

    a_flush: assert property (@(posedge g_clk) disable iff (!i_rst_n)
        i_flush |=> !o_valid)
        else $error("o_valid high after flush");

endmodule

bind ex_stage_top ex_stage_assert u_assert (.*);

// ==== sim/tb_ex_stage.sv ====
/*
  Testbench of the execute stage. Inputs change on the falling edge.
  Expected register contents come from a model queued at acceptance.
  Flush is only raised while i_busy is high, so a flushed item never leaves.
*/
`timescale 1ns/1ns

module tb_ex_stage;

    localparam int N_TXN     = 140;             // Upper bound on sent items
    localparam int CYC_LIMIT = N_TXN * 4 + 100;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] res_a;
        logic [31:0] res_b;
        logic [4:0]  uop;
        logic [3:0]  fu;
        logic        trap;
    } beat_t;

    logic g_clk, i_rst_n, i_valid, i_flush, i_busy, i_trap;
    logic o_busy, o_valid, o_fwd_load, o_fwd_csr, o_trap;
    logic [4:0]  i_rd, i_uop, o_rd, o_uop, o_fwd_rd;
    logic [3:0]  i_fu, o_fu;
    logic [31:0] i_opr_a, i_opr_b, i_opr_c, o_fwd_wdata, o_res_a, o_res_b;

    beat_t       exp_q[$];
    logic [31:0] lfsr_state = 32'h0726_e3a9;
    logic [31:0] model_res_b = '0;              // Mirrors the hold of o_res_b
    logic        busy_rand = 1'b0;
    logic        busy_force = 1'b0;
    logic        flush_prev = 1'b0;
    int          err_cnt = 0;
    int          beat_cnt = 0;
    int          drop_cnt = 0;
    int          cycles = 0;

    ex_stage_top UUT (.*);

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    // Reference model of the output register for one accepted input
    function automatic beat_t model(input logic [3:0] fu, input logic [4:0] uop,
                                    input logic [31:0] a, input logic [31:0] b,
                                    input logic [31:0] c, input logic [4:0] rd,
                                    input logic trap, input logic [31:0] prev_b);
        beat_t m;
        logic  tk;
        m = '{rd: rd, res_a: '0, res_b: prev_b, uop: uop, fu: fu, trap: trap};
        if (fu[ex_pkg::FU_ALU]) begin
            case (uop)
                ex_pkg::ALU_ADD:  m.res_a = a + b;
                ex_pkg::ALU_SUB:  m.res_a = a - b;
                ex_pkg::ALU_XOR:  m.res_a = a ^ b;
                ex_pkg::ALU_OR:   m.res_a = a | b;
                ex_pkg::ALU_AND:  m.res_a = a & b;
                ex_pkg::ALU_SLL:  m.res_a = a << b[4:0];
                ex_pkg::ALU_SRL:  m.res_a = a >> b[4:0];
                ex_pkg::ALU_SRA:  m.res_a = $signed(a) >>> b[4:0];
                ex_pkg::ALU_SLT:  m.res_a = {31'd0, $signed(a) < $signed(b)};
                ex_pkg::ALU_SLTU: m.res_a = {31'd0, a < b};
                default:          m.res_a = '0;
            endcase
        end else if (fu[ex_pkg::FU_LSU]) begin
            m.res_a = a + b;                                // Effective address
        end else if (fu[ex_pkg::FU_CFU]) begin
            m.res_a = (uop == ex_pkg::CFU_JALR) ? ((a + b) & ~32'd1) : (c & ~32'd1);
            if (uop[4:3] == 2'b00) begin
                case (uop)
                    ex_pkg::CFU_BEQ:  tk = (a == b);
                    ex_pkg::CFU_BNE:  tk = (a != b);
                    ex_pkg::CFU_BLT:  tk = ($signed(a) < $signed(b));
                    ex_pkg::CFU_BGE:  tk = ($signed(a) >= $signed(b));
                    ex_pkg::CFU_BLTU: tk = (a < b);
                    default:          tk = (a >= b);          // BGEU
                endcase
                m.uop = tk ? ex_pkg::CFU_TAKEN : ex_pkg::CFU_NOT_TAKEN;
            end
        end else if (fu[ex_pkg::FU_CSR]) begin
            m.res_a = a;
        end
        if (trap) begin
            m.res_b = {27'd0, rd};                          // Cause in rd
        end else if ((fu[ex_pkg::FU_LSU] && uop[ex_pkg::LSU_STORE_BIT]) ||
                     fu[ex_pkg::FU_CSR]) begin
            m.res_b = c;
        end
        return m;
    endfunction

    // ----------------------------------------------------------------------
    // Monitor: output beats, acceptance, flush and timeout
    // ----------------------------------------------------------------------
    always @(posedge g_clk) begin
        beat_t m;
        beat_t h;
        cycles++;
        if (cycles > CYC_LIMIT) begin
            $display("Timeout after %0d cycles, the stage stopped making progress", cycles);
            $display("ERRORS FOUND");
            $finish;
        end else if (i_rst_n) begin
            if (flush_prev) check_val("o_valid after flush", 32'd0, {31'd0, o_valid});
            if (o_valid && (i_flush || !i_busy)) begin
                if (exp_q.size() == 0) begin
                    $display("Output beat at %0t ns with no accepted item behind it", $time);
                    err_cnt++;
                end else if (i_flush) begin
                    void'(exp_q.pop_front());               // Dropped, never leaves
                    drop_cnt++;
                end else begin
                    h = exp_q.pop_front();
                    beat_cnt++;
                    check_val("o_rd", {27'd0, h.rd}, {27'd0, o_rd});
                    check_val("o_res_a", h.res_a, o_res_a);
                    check_val("o_res_b", h.res_b, o_res_b);
                    check_val("o_uop", {27'd0, h.uop}, {27'd0, o_uop});
                    check_val("o_fu", {28'd0, h.fu}, {28'd0, o_fu});
                    check_val("o_trap", {31'd0, h.trap}, {31'd0, o_trap});
                end
            end
            if (i_valid && !o_busy && !i_flush) begin
                m = model(i_fu, i_uop, i_opr_a, i_opr_b, i_opr_c, i_rd, i_trap, model_res_b);
                check_val("o_fwd_wdata", m.res_a, o_fwd_wdata);
                check_val("o_fwd_rd", {27'd0, i_rd}, {27'd0, o_fwd_rd});
                check_val("o_fwd_load", {31'd0, i_fu[ex_pkg::FU_LSU] &&
                          i_uop[ex_pkg::LSU_LOAD_BIT]}, {31'd0, o_fwd_load});
                check_val("o_fwd_csr", {31'd0, i_fu[ex_pkg::FU_CSR]}, {31'd0, o_fwd_csr});
                exp_q.push_back(m);
                model_res_b = m.res_b;
            end
            flush_prev = i_flush;
        end
    end

    task automatic drive_busy();
        i_busy = busy_rand ? (rand_bits(2) == 32'd3) : busy_force;  // A quarter busy
    endtask

    // One item, held until the stage can take it
    task automatic send(input logic [3:0] fu, input logic [4:0] uop, input logic [31:0] a,
                        input logic [31:0] b, input logic [31:0] c, input logic [4:0] rd,
                        input logic trap);
        @(negedge g_clk);
        drive_busy();
        {i_valid, i_fu, i_uop, i_opr_a, i_opr_b, i_opr_c, i_rd, i_trap} =
            {1'b1, fu, uop, a, b, c, rd, trap};
        #1;
        while (o_busy) begin
            @(negedge g_clk);
            drive_busy();
            #1;
        end
    endtask

    task automatic drain();
        @(negedge g_clk);
        i_valid = 1'b0;
        drive_busy();
        while (exp_q.size() != 0 || o_valid) begin
            @(negedge g_clk);
            drive_busy();
        end
    endtask

    task automatic report(input string name, input int err_before);
        drain();
        $display("Test %-12s %0d mismatches", name, err_cnt - err_before);
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        ex_pkg::alu_op_e op;
        logic [4:0]  br_ops [6];
        logic [4:0]  jmp_ops [3];
        logic [31:0] a;
        int          e0;
        {i_valid, i_flush, i_busy, i_trap, i_rd, i_uop, i_fu} = '0;
        {i_opr_a, i_opr_b, i_opr_c} = '0;
        i_rst_n = 1'b0;
        br_ops  = '{ex_pkg::CFU_BEQ, ex_pkg::CFU_BNE, ex_pkg::CFU_BLT,
                    ex_pkg::CFU_BGE, ex_pkg::CFU_BLTU, ex_pkg::CFU_BGEU};
        jmp_ops = '{ex_pkg::CFU_JMP, ex_pkg::CFU_JALI, ex_pkg::CFU_JALR};
        repeat (2) @(negedge g_clk);
        i_rst_n = 1'b1;

        e0 = err_cnt;                                       // ALU functions
        op = op.first();
        for (int k = 0; k < op.num(); k++) begin
            repeat (4) send(4'b0001, op, rand_bits(32), rand_bits(32), rand_bits(32),
                            rand_bits(5), 1'b0);
            op = op.next();
        end
        report("alu", e0);

        e0 = err_cnt;                                       // Branches, equal operands too
        foreach (br_ops[k]) begin
            for (int j = 0; j < 4; j++) begin
                a = rand_bits(32);
                send(4'b0100, br_ops[k], a, j[0] ? a : rand_bits(32), rand_bits(32),
                     rand_bits(5), 1'b0);
            end
        end
        foreach (jmp_ops[k]) begin
            repeat (2) send(4'b0100, jmp_ops[k], rand_bits(32), rand_bits(32),
                            rand_bits(32), rand_bits(5), 1'b0);
        end
        report("branch/jump", e0);

        e0 = err_cnt;                                       // Loads then stores
        repeat (6) send(4'b0010, 5'b01_010, rand_bits(32), rand_bits(32), rand_bits(32),
                        rand_bits(5), 1'b0);
        repeat (6) send(4'b0010, 5'b10_010, rand_bits(32), rand_bits(32), rand_bits(32),
                        rand_bits(5), 1'b0);
        report("load/store", e0);

        e0 = err_cnt;                                       // CSR and traps
        repeat (4) send(4'b1000, rand_bits(3), rand_bits(32), rand_bits(32), rand_bits(32),
                        rand_bits(5), 1'b0);
        repeat (4) send(4'b0001, ex_pkg::ALU_ADD, rand_bits(32), rand_bits(32),
                        rand_bits(32), rand_bits(5), 1'b1);
        report("csr/trap", e0);

        e0 = err_cnt;                                       // Random back-pressure
        busy_rand = 1'b1;
        repeat (40) send(4'b0001, ex_pkg::ALU_XOR, rand_bits(32), rand_bits(32),
                         rand_bits(32), rand_bits(5), 1'b0);
        drain();
        busy_rand = 1'b0;
        report("backpressure", e0);

        e0 = err_cnt;                                       // Flush a held item
        busy_force = 1'b1;
        send(4'b0001, ex_pkg::ALU_OR, rand_bits(32), rand_bits(32), 32'd0, 5'd7, 1'b0);
        @(negedge g_clk);
        i_valid = 1'b0;
        i_flush = 1'b1;
        @(negedge g_clk);
        i_flush    = 1'b0;
        busy_force = 1'b0;
        i_busy     = 1'b0;
        send(4'b0001, ex_pkg::ALU_AND, rand_bits(32), rand_bits(32), 32'd0, 5'd9, 1'b0);
        if (drop_cnt != 1) begin
            $display("Flush dropped %0d items instead of one", drop_cnt);
            err_cnt++;
        end
        report("flush", e0);

        $display("Done: %0d beats checked, %0d dropped, %0d errors",
                 beat_cnt, drop_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== source/ex_alu.sv ====
/*
  Single-cycle ALU with one shared adder/subtractor.
  Compare outputs are only meaningful when decode selected SUB, SLT or SLTU.
  add_out equals opr_a + opr_b whenever the function is ADD.
*/
`timescale 1ns/1ns

module ex_alu (
    ex_op_if.exec io_op  // Function in, results out
);

    localparam int XL = ex_pkg::XLEN;

    logic                      do_sub;    // Invert opr_b and carry in
    logic [XL-1:0]             opr_b_op;  // Adder right hand side
    logic [XL:0]               sum_ext;   // Sum with carry out
    logic [XL-1:0]             sum;
    logic [ex_pkg::SHAMT_W-1:0] shamt;
    logic [XL-1:0]             sll_out;
    logic [XL-1:0]             srl_out;
    logic [XL-1:0]             sra_out;
    logic                      cmp_eq;
    logic                      cmp_lt;
    logic                      cmp_ltu;

    // ----------------------------------------------------------------------
    // Adder / subtractor
    // ----------------------------------------------------------------------
    assign do_sub = (io_op.alu_fn == ex_pkg::ALU_SUB) ||
                    (io_op.alu_fn == ex_pkg::ALU_SLT) ||
                    (io_op.alu_fn == ex_pkg::ALU_SLTU);

    assign opr_b_op = io_op.opr_b ^ {XL{do_sub}};               // One's complement
    assign sum_ext  = {1'b0, io_op.opr_a} + {1'b0, opr_b_op} +
                      {{XL{1'b0}}, do_sub};                     // +1 completes negate
    assign sum      = sum_ext[XL-1:0];

    assign io_op.add_out = sum;

    // Comparators from the difference
    assign cmp_eq  = (sum == '0);
    assign cmp_ltu = !sum_ext[XL];                               // Borrow out
    assign cmp_lt  = (io_op.opr_a[XL-1] != io_op.opr_b[XL-1]) ?
                     io_op.opr_a[XL-1] :                         // Signs differ
                     sum[XL-1];                                  // Same sign, no overflow

    // ----------------------------------------------------------------------
    // Shifter
    // ----------------------------------------------------------------------
    assign shamt   = io_op.opr_b[ex_pkg::SHAMT_W-1:0];
    assign sll_out = io_op.opr_a << shamt;
    assign srl_out = io_op.opr_a >> shamt;
    assign sra_out = $signed(io_op.opr_a) >>> shamt;             // Sign fill

    // Function mux
    always_comb begin
        case (io_op.alu_fn)
            ex_pkg::ALU_ADD,
            ex_pkg::ALU_SUB:  io_op.alu_result = sum;
            ex_pkg::ALU_XOR:  io_op.alu_result = io_op.opr_a ^ io_op.opr_b;
            ex_pkg::ALU_OR:   io_op.alu_result = io_op.opr_a | io_op.opr_b;
            ex_pkg::ALU_AND:  io_op.alu_result = io_op.opr_a & io_op.opr_b;
            ex_pkg::ALU_SLL:  io_op.alu_result = sll_out;
            ex_pkg::ALU_SRL:  io_op.alu_result = srl_out;
            ex_pkg::ALU_SRA:  io_op.alu_result = sra_out;
            ex_pkg::ALU_SLT:  io_op.alu_result = {{(XL-1){1'b0}}, cmp_lt};
            ex_pkg::ALU_SLTU: io_op.alu_result = {{(XL-1){1'b0}}, cmp_ltu};
            default:          io_op.alu_result = '0;             // Undefined code
        endcase
    end

    // ----------------------------------------------------------------------
    // Branch condition
    // ----------------------------------------------------------------------
    always_comb begin
        case (io_op.br_cond)
            ex_pkg::BR_EQ:  io_op.br_taken = cmp_eq;
            ex_pkg::BR_NE:  io_op.br_taken = !cmp_eq;
            ex_pkg::BR_LT:  io_op.br_taken = cmp_lt;
            ex_pkg::BR_GE:  io_op.br_taken = !cmp_lt;
            ex_pkg::BR_LTU: io_op.br_taken = cmp_ltu;
            ex_pkg::BR_GEU: io_op.br_taken = !cmp_ltu;
            default:        io_op.br_taken = 1'b0;               // Not a branch
        endcase
    end

endmodule

// ==== source/ex_decode.sv ====
/*
  Maps unit and micro-op onto an ALU function and a branch condition.
  ALU micro-ops pass straight through as the function code.
  Combinational, no latency.
*/
`timescale 1ns/1ns

module ex_decode (
    input  logic [ex_pkg::FU_W-1:0]  i_fu,     // One-hot functional unit
    input  logic [ex_pkg::UOP_W-1:0] i_uop,    // Micro-op
    input  logic [ex_pkg::XLEN-1:0]  i_opr_a,
    input  logic [ex_pkg::XLEN-1:0]  i_opr_b,
    input  logic [ex_pkg::XLEN-1:0]  i_opr_c,
    ex_op_if.decode                  o_op      // Decoded op to ALU and result
);

    logic fu_alu;
    logic fu_cfu;
    logic cfu_cond;    // Conditional branch

    assign fu_alu   = i_fu[ex_pkg::FU_ALU];
    assign fu_cfu   = i_fu[ex_pkg::FU_CFU];
    assign cfu_cond = fu_cfu && (i_uop[ex_pkg::UOP_W-1 -: 2] == ex_pkg::CFU_GRP_COND);

    // ----------------------------------------------------------------------
    // Function select
    // ----------------------------------------------------------------------
    always_comb begin
        if (fu_alu) begin
            o_op.alu_fn = ex_pkg::alu_op_e'(i_uop);  // Same encoding
        end else if (cfu_cond) begin
            o_op.alu_fn = ex_pkg::ALU_SUB;           // Comparators run off subtract
        end else begin
            o_op.alu_fn = ex_pkg::ALU_ADD;           // Load/store address, jalr target
        end
    end

    // Branch condition, NONE outside the conditional group
    always_comb begin
        o_op.br_cond = ex_pkg::BR_NONE;
        if (cfu_cond) begin
            case (i_uop)
                ex_pkg::CFU_BEQ:  o_op.br_cond = ex_pkg::BR_EQ;
                ex_pkg::CFU_BNE:  o_op.br_cond = ex_pkg::BR_NE;
                ex_pkg::CFU_BLT:  o_op.br_cond = ex_pkg::BR_LT;
                ex_pkg::CFU_BGE:  o_op.br_cond = ex_pkg::BR_GE;
                ex_pkg::CFU_BLTU: o_op.br_cond = ex_pkg::BR_LTU;
                ex_pkg::CFU_BGEU: o_op.br_cond = ex_pkg::BR_GEU;
                default:          o_op.br_cond = ex_pkg::BR_NONE;  // Unused code
            endcase
        end
    end

    // Operands and unit go through untouched
    assign o_op.fu    = i_fu;
    assign o_op.opr_a = i_opr_a;
    assign o_op.opr_b = i_opr_b;
    assign o_op.opr_c = i_opr_c;

endmodule

// ==== source/ex_op_if.sv ====
/*
  Decoded operation and ALU results shared inside the execute stage.
  Purely combinational, no clock.
*/
`timescale 1ns/1ns

interface ex_op_if;

    logic [ex_pkg::FU_W-1:0] fu;          // One-hot unit
    ex_pkg::alu_op_e         alu_fn;      // Selected ALU function
    ex_pkg::br_cond_e        br_cond;     // Branch condition, NONE if not a branch
    logic [ex_pkg::XLEN-1:0] opr_a;
    logic [ex_pkg::XLEN-1:0] opr_b;
    logic [ex_pkg::XLEN-1:0] opr_c;       // Store data, link target or CSR data

    logic [ex_pkg::XLEN-1:0] alu_result;  // Output of selected function
    logic [ex_pkg::XLEN-1:0] add_out;     // Shared adder output
    logic                    br_taken;    // Condition holds

    // Decoder drives op fields
    modport decode (output fu, alu_fn, br_cond, opr_a, opr_b, opr_c);

    // ALU computes from them
    modport exec (input alu_fn, br_cond, opr_a, opr_b,
                  output alu_result, add_out, br_taken);

    // Result stage sees everything
    modport result (input fu, alu_fn, br_cond, opr_a, opr_b, opr_c,
                    alu_result, add_out, br_taken);

endinterface

// ==== source/ex_pkg.sv ====
/*
  Widths, functional unit indices and micro-op encodings of the execute stage.
  Widths are fixed by RV32 and are not meant to be changed.
  Conditional branches must keep 2'b00 in the top two micro-op bits.
*/
package ex_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int XLEN    = 32;            // Data word
    localparam int RD_W    = 5;             // Register address
    localparam int UOP_W   = 5;             // Micro-op code
    localparam int FU_W    = 4;             // One-hot functional unit
    localparam int SHAMT_W = $clog2(XLEN);  // Shift amount bits of opr_b

    // Bit positions inside the one-hot unit field
    localparam int FU_ALU = 0;
    localparam int FU_LSU = 1;
    localparam int FU_CFU = 2;
    localparam int FU_CSR = 3;

    // LSU micro-op flags, low bits left for size and sign
    localparam int LSU_LOAD_BIT  = 3;
    localparam int LSU_STORE_BIT = 4;

    // Top-two-bit group of conditional branches
    localparam logic [1:0] CFU_GRP_COND = 2'b00;

    // ----------------------------------------------------------------------
    // Operation encodings
    // ----------------------------------------------------------------------
    typedef enum logic [UOP_W-1:0] {
        ALU_ADD  = 5'b00_000,
        ALU_SUB  = 5'b00_001,
        ALU_XOR  = 5'b00_010,
        ALU_OR   = 5'b00_011,
        ALU_AND  = 5'b00_100,
        ALU_SLL  = 5'b01_000,
        ALU_SRL  = 5'b01_001,
        ALU_SRA  = 5'b01_010,
        ALU_SLT  = 5'b10_000,
        ALU_SLTU = 5'b10_001
    } alu_op_e;

    typedef enum logic [UOP_W-1:0] {
        CFU_BEQ       = 5'b00_001,  // Conditional group 00
        CFU_BNE       = 5'b00_010,
        CFU_BLT       = 5'b00_011,
        CFU_BGE       = 5'b00_100,
        CFU_BLTU      = 5'b00_101,
        CFU_BGEU      = 5'b00_110,
        CFU_JMP       = 5'b10_001,  // Unconditional group 10
        CFU_JALI      = 5'b10_010,
        CFU_JALR      = 5'b10_100,
        CFU_NOT_TAKEN = 5'b11_000,  // Branch outcome, rewritten here
        CFU_TAKEN     = 5'b11_001
    } cfu_op_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } br_cond_e;

endpackage

// ==== source/ex_result.sv ====
/*
  Per-unit result select and the single output pipeline register.
  One item held at most, no skid buffer, so o_busy follows i_busy while full.
  o_res_b loads only for stores, CSR ops and traps.
*/
`timescale 1ns/1ns

module ex_result (
    input  logic                      g_clk,
    input  logic                      i_rst_n,      // Async, active low
    ex_op_if.result                   i_op,         // Decoded op and ALU results
    input  logic [ex_pkg::RD_W-1:0]   i_rd,
    input  logic [ex_pkg::UOP_W-1:0]  i_uop,
    input  logic                      i_trap,       // Cause sits in rd
    input  logic                      i_valid,
    input  logic                      i_flush,
    input  logic                      i_busy,       // Writeback stalled
    output logic                      o_busy,
    output logic                      o_valid,
    output logic [ex_pkg::RD_W-1:0]   o_rd,
    output logic [ex_pkg::XLEN-1:0]   o_res_a,
    output logic [ex_pkg::XLEN-1:0]   o_res_b,
    output logic [ex_pkg::UOP_W-1:0]  o_uop,
    output logic [ex_pkg::FU_W-1:0]   o_fu,
    output logic                      o_trap,
    output logic [ex_pkg::XLEN-1:0]   o_fwd_wdata,  // Same cycle as input
    output logic                      o_fwd_load,
    output logic                      o_fwd_csr
);

    localparam int XL = ex_pkg::XLEN;

    logic                     fu_alu;
    logic                     fu_lsu;
    logic                     fu_cfu;
    logic                     fu_csr;
    logic                     lsu_load;
    logic                     lsu_store;
    logic                     cfu_cond;
    logic                     cfu_jalr;
    logic                     accept;     // Item enters register this edge
    logic                     ld_res_b;
    logic [XL-1:0]            n_res_a;
    logic [XL-1:0]            n_res_b;
    logic [ex_pkg::UOP_W-1:0] n_uop;

    assign fu_alu    = i_op.fu[ex_pkg::FU_ALU];
    assign fu_lsu    = i_op.fu[ex_pkg::FU_LSU];
    assign fu_cfu    = i_op.fu[ex_pkg::FU_CFU];
    assign fu_csr    = i_op.fu[ex_pkg::FU_CSR];
    assign lsu_load  = fu_lsu && i_uop[ex_pkg::LSU_LOAD_BIT];
    assign lsu_store = fu_lsu && i_uop[ex_pkg::LSU_STORE_BIT];
    assign cfu_cond  = fu_cfu && (i_uop[ex_pkg::UOP_W-1 -: 2] == ex_pkg::CFU_GRP_COND);
    assign cfu_jalr  = fu_cfu && (i_uop == ex_pkg::CFU_JALR);

    // ----------------------------------------------------------------------
    // Next-state values
    // ----------------------------------------------------------------------
    always_comb begin
        n_res_a = '0;
        if (fu_alu) begin
            n_res_a = i_op.alu_result;
        end else if (fu_lsu) begin
            n_res_a = i_op.add_out;                       // Effective address
        end else if (cfu_jalr) begin
            n_res_a = {i_op.add_out[XL-1:1], 1'b0};       // rs1 + imm, bit 0 cleared
        end else if (fu_cfu) begin
            n_res_a = {i_op.opr_c[XL-1:1], 1'b0};         // Precomputed target
        end else if (fu_csr) begin
            n_res_a = i_op.opr_a;                         // CSR write data
        end
    end

    // Trap cause wins over store or CSR data
    assign n_res_b = i_trap ? {{(XL-ex_pkg::RD_W){1'b0}}, i_rd} : i_op.opr_c;

    assign n_uop = !cfu_cond    ? i_uop                  :
                   i_op.br_taken ? ex_pkg::CFU_TAKEN      :
                                   ex_pkg::CFU_NOT_TAKEN;

    // ----------------------------------------------------------------------
    // Handshake
    // ----------------------------------------------------------------------
    assign o_busy   = o_valid && i_busy;
    assign accept   = i_valid && !o_busy && !i_flush;     // Flush blocks entry
    assign ld_res_b = accept && (i_trap || lsu_store || fu_csr);

    always_ff @(posedge g_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;                              // Drop held item
        end else if (accept) begin
            o_valid <= 1'b1;
        end else if (!i_busy) begin
            o_valid <= 1'b0;                              // Item left, nothing new
        end
    end

    // Output register, loads only on acceptance
    always_ff @(posedge g_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rd    <= '0;
            o_res_a <= '0;
            o_res_b <= '0;
            o_uop   <= '0;
            o_fu    <= '0;
            o_trap  <= 1'b0;
        end else begin
            if (accept) begin
                o_rd    <= i_rd;
                o_res_a <= n_res_a;
                o_uop   <= n_uop;
                o_fu    <= i_op.fu;
                o_trap  <= i_trap;
            end
            if (ld_res_b) begin
                o_res_b <= n_res_b;                       // Otherwise keeps old value
            end
        end
    end

    // Forwarding straight from next-state values
    assign o_fwd_wdata = n_res_a;
    assign o_fwd_load  = lsu_load;
    assign o_fwd_csr   = fu_csr;

endmodule

// ==== source/ex_stage_top.sv ====
/*
  Execute stage top. One instruction per valid/busy handshake, one cycle latency.
  Forwarding outputs reflect the current inputs, unregistered.
*/
`timescale 1ns/1ns

module ex_stage_top (
    input  logic                      g_clk,
    input  logic                      i_rst_n,
    // Upstream handshake
    input  logic                      i_valid,
    output logic                      o_busy,
    input  logic                      i_flush,
    // Decoded instruction
    input  logic [ex_pkg::RD_W-1:0]   i_rd,
    input  logic [ex_pkg::XLEN-1:0]   i_opr_a,
    input  logic [ex_pkg::XLEN-1:0]   i_opr_b,
    input  logic [ex_pkg::XLEN-1:0]   i_opr_c,
    input  logic [ex_pkg::UOP_W-1:0]  i_uop,
    input  logic [ex_pkg::FU_W-1:0]   i_fu,
    input  logic                      i_trap,
    // Forwarding
    output logic [ex_pkg::RD_W-1:0]   o_fwd_rd,
    output logic [ex_pkg::XLEN-1:0]   o_fwd_wdata,
    output logic                      o_fwd_load,
    output logic                      o_fwd_csr,
    // Downstream handshake and payload
    output logic                      o_valid,
    input  logic                      i_busy,
    output logic [ex_pkg::RD_W-1:0]   o_rd,
    output logic [ex_pkg::XLEN-1:0]   o_res_a,
    output logic [ex_pkg::XLEN-1:0]   o_res_b,
    output logic [ex_pkg::UOP_W-1:0]  o_uop,
    output logic [ex_pkg::FU_W-1:0]   o_fu,
    output logic                      o_trap
);

    ex_op_if op_if ();  // Decode to ALU to result

    ex_decode u_decode (
        .i_fu    (i_fu),
        .i_uop   (i_uop),
        .i_opr_a (i_opr_a),
        .i_opr_b (i_opr_b),
        .i_opr_c (i_opr_c),
        .o_op    (op_if.decode)
    );

    ex_alu u_alu (
        .io_op (op_if.exec)
    );

    ex_result u_result (
        .g_clk       (g_clk),
        .i_rst_n     (i_rst_n),
        .i_op        (op_if.result),
        .i_rd        (i_rd),
        .i_uop       (i_uop),
        .i_trap      (i_trap),
        .i_valid     (i_valid),
        .i_flush     (i_flush),
        .i_busy      (i_busy),
        .o_busy      (o_busy),
        .o_valid     (o_valid),
        .o_rd        (o_rd),
        .o_res_a     (o_res_a),
        .o_res_b     (o_res_b),
        .o_uop       (o_uop),
        .o_fu        (o_fu),
        .o_trap      (o_trap),
        .o_fwd_wdata (o_fwd_wdata),
        .o_fwd_load  (o_fwd_load),
        .o_fwd_csr   (o_fwd_csr)
    );

    assign o_fwd_rd = i_rd;  // Destination of the op now in execute

endmodule

// ==== vlog.f ====
source/ex_pkg.sv
source/ex_op_if.sv
source/ex_decode.sv
source/ex_alu.sv
source/ex_result.sv
source/ex_stage_top.sv
sim/ex_stage_assert.sv
sim/tb_ex_stage.sv
